/* compile.f */
logic/breath_pkg.sv
logic/timebase_if.sv
logic/duty_if.sv
logic/breath_timebase.sv
logic/breath_envelope.sv
logic/pwm_stage.sv
logic/rgb_breath_top.sv
testbench/tb_rgb_breath_top.sv

/* Bender.yml */
package:
  name: rgb_breath

sources:
  # RTL in compile order
  - files:
      - logic/breath_pkg.sv
      - logic/timebase_if.sv
      - logic/duty_if.sv
      - logic/breath_timebase.sv
      - logic/breath_envelope.sv
      - logic/pwm_stage.sv
      - logic/rgb_breath_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/tb_rgb_breath_top.sv

/* testbench/tb_rgb_breath_top.sv */
/*
 * Testbench for the RGB breathing LED controller
 * Drives modes and levels, models each period's duty per channel
 * and checks every LED line on every clock edge
 */

`timescale 1ns/1ps

module tb_rgb_breath_top;

  localparam int clk_half    = 4;     // 8 ns clock
  localparam int period_len  = 256;   // Cycles per PWM period with no prescale
  localparam int wait_limit  = 8192;  // Cycles allowed per wait
  localparam int last_period = 264;   // Runs past the phase flip at period 256

  logic                         clk;
  logic                         arst_n;
  breath_pkg::chan_mode_e       mode_r;
  breath_pkg::chan_mode_e       mode_g;
  breath_pkg::chan_mode_e       mode_b;
  logic [breath_pkg::pwm_w-1:0] level_r;
  logic [breath_pkg::pwm_w-1:0] level_g;
  logic [breath_pkg::pwm_w-1:0] level_b;
  logic                         led_r;
  logic                         led_g;
  logic                         led_b;

  int seed = 19;
  int cyc = 0;      // Clock edges since reset release
  int errors = 0;
  int checks = 0;
  int pend_duty [breath_pkg::num_chan];  // Taken at period_start
  int act_duty [breath_pkg::num_chan];   // Duty shown on the lines now
  logic [breath_pkg::num_chan-1:0] exp_led = '0;

  rgb_breath_top #(
    .prescale_w (0)  // One ramp step per 256-cycle period
  ) i_rgb_breath_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .mode_r  (mode_r),
    .mode_g  (mode_g),
    .mode_b  (mode_b),
    .level_r (level_r),
    .level_g (level_g),
    .level_b (level_b),
    .led_r   (led_r),
    .led_g   (led_g),
    .led_b   (led_b)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  // Duty of one channel in PWM period p
  function automatic int expected_duty(input breath_pkg::chan_mode_e mode,
                                       input int level, input int p);
    int ramp;
    int ph;
    int tri_v;
    int res;
    ramp  = p % 256;        // Ramp steps once per period
    ph    = (p / 256) % 2;  // Top counter bit
    tri_v = (ph == 1) ? 255 - ramp : ramp;
    case (mode)
      breath_pkg::mode_steady:  res = level;
      breath_pkg::mode_breathe: res = (tri_v * level) / 256;  // Upper byte of product
      breath_pkg::mode_blink:   res = (ph == 0) ? level : 0;
      default:                  res = 0;
    endcase
    return res;
  endfunction

  function automatic logic [breath_pkg::pwm_w-1:0] rand_level();
    return breath_pkg::pwm_w'($random(seed));
  endfunction

  // Mid-point of period q, away from the sampling edge
  function automatic int mid_period(input int q);
    return q * period_len + 128;
  endfunction

  // Reference model, expected LED value after each edge
  always @(posedge clk or negedge arst_n) begin : model
    int e;
    int k;
    if (!arst_n) begin
      cyc     <= 0;
      exp_led <= '0;
      for (int i = 0; i < breath_pkg::num_chan; i++) begin
        pend_duty[i] = 0;
        act_duty[i]  = 0;  // Lines dark after reset
      end
    end else begin
      e = cyc + 1;
      cyc <= e;
      // Envelope samples modes and levels one edge after period_start
      if (e >= 2 && (e - 2) % period_len == 0) begin
        pend_duty[breath_pkg::chan_r] = expected_duty(mode_r, level_r, (e - 2) / period_len);
        pend_duty[breath_pkg::chan_g] = expected_duty(mode_g, level_g, (e - 2) / period_len);
        pend_duty[breath_pkg::chan_b] = expected_duty(mode_b, level_b, (e - 2) / period_len);
      end
      if (e >= 4) begin
        k = (e - 4) % period_len;  // PWM step on the lines
        if (k == 0) begin
          act_duty = pend_duty;  // New period reaches the outputs
        end
        for (int i = 0; i < breath_pkg::num_chan; i++) begin
          exp_led[i] <= (k < act_duty[i]);
        end
      end else begin
        exp_led <= '0;  // Pipeline still filling
      end
      checks <= checks + breath_pkg::num_chan;
    end
  end

  task automatic report_mismatch(input string name, input logic exp_v, input logic act_v);
    errors++;
    $display("ERR %0t %s expected %b actual %b", $time, name, exp_v, act_v);
  endtask

  // Wait until the given edge since release
  task automatic wait_edge(input int target);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (cyc + 1 < target && n < wait_limit);
    if (cyc + 1 < target) begin
      $display("Timed out at %0t waiting for clock edge %0d", $time, target);
      errors++;
    end
  endtask

  // Each line against the model, every edge
  led_r_check: assert property (@(posedge clk) led_r == exp_led[breath_pkg::chan_r])
    else report_mismatch("led_r", $sampled(exp_led[breath_pkg::chan_r]), $sampled(led_r));
  led_g_check: assert property (@(posedge clk) led_g == exp_led[breath_pkg::chan_g])
    else report_mismatch("led_g", $sampled(exp_led[breath_pkg::chan_g]), $sampled(led_g));
  led_b_check: assert property (@(posedge clk) led_b == exp_led[breath_pkg::chan_b])
    else report_mismatch("led_b", $sampled(exp_led[breath_pkg::chan_b]), $sampled(led_b));

  initial begin : stimulus
    arst_n  = 1'b1;
    mode_r  = breath_pkg::mode_off;
    mode_g  = breath_pkg::mode_off;
    mode_b  = breath_pkg::mode_off;
    level_r = '0;
    level_g = '0;
    level_b = '0;
    #1;
    arst_n = 1'b0;  // Clean falling edge into reset
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    // Steady red, green off, blue breathing at full level
    wait_edge(mid_period(0));
    mode_r  <= breath_pkg::mode_steady;
    level_r <= rand_level();
    mode_b  <= breath_pkg::mode_breathe;
    level_b <= 8'hff;

    wait_edge(mid_period(2));
    level_r <= rand_level();  // Lands on period 3

    wait_edge(mid_period(3));
    level_r <= rand_level();
    mode_g  <= breath_pkg::mode_steady;
    level_g <= rand_level();

    wait_edge(mid_period(5));
    mode_r <= breath_pkg::mode_off;  // Off after steady

    // Blink red, breathe green, steady blue, all three in different modes
    wait_edge(mid_period(7));
    mode_r  <= breath_pkg::mode_blink;
    level_r <= rand_level();
    mode_g  <= breath_pkg::mode_breathe;
    level_g <= rand_level();
    mode_b  <= breath_pkg::mode_steady;
    level_b <= rand_level();

    for (int q = 16; q < 248; q += 16) begin
      wait_edge(mid_period(q));
      level_r <= rand_level();
      level_g <= rand_level();
      level_b <= rand_level();
    end

    // Full level on green and blue breathing through the phase flip
    wait_edge(mid_period(248));
    level_g <= 8'hff;
    level_r <= rand_level();
    mode_b  <= breath_pkg::mode_breathe;
    level_b <= 8'hff;

    // Zero level during ramp-down
    wait_edge(mid_period(259));
    level_b <= 8'h00;

    wait_edge(mid_period(262));
    level_b <= 8'hff;
    level_g <= rand_level();

    wait_edge(last_period * period_len + 8);
    @(negedge clk);  // Let the last assertions settle
    $display("Closing counts: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* logic/rgb_breath_top.sv */
/*
 * RGB breathing LED controller top level
 * Timebase, envelope and PWM stages for three independent channels
 */

`timescale 1ns/1ps

module rgb_breath_top #(
  parameter int unsigned prescale_w = breath_pkg::prescale_w_default
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  breath_pkg::chan_mode_e       mode_r,   // Red channel mode
  input  breath_pkg::chan_mode_e       mode_g,
  input  breath_pkg::chan_mode_e       mode_b,
  input  logic [breath_pkg::pwm_w-1:0] level_r,  // Peak duty, red
  input  logic [breath_pkg::pwm_w-1:0] level_g,
  input  logic [breath_pkg::pwm_w-1:0] level_b,
  output logic                         led_r,    // PWM lines to the LED driver
  output logic                         led_g,
  output logic                         led_b
);

  // Counter fields, timebase to both later stages
  timebase_if i_tb_if ();

  // Duties, envelope to PWM
  duty_if i_duty_if ();

  // Prescaled free-running counter
  breath_timebase #(
    .prescale_w (prescale_w)
  ) i_breath_timebase (
    .clk    (clk),
    .arst_n (arst_n),
    .tb     (i_tb_if.src)
  );

  // Mode and level to duty, once per period
  breath_envelope i_breath_envelope (
    .clk     (clk),
    .arst_n  (arst_n),
    .tb      (i_tb_if.snk),
    .mode_r  (mode_r),
    .mode_g  (mode_g),
    .mode_b  (mode_b),
    .level_r (level_r),
    .level_g (level_g),
    .level_b (level_b),
    .duty    (i_duty_if.src)
  );

  // Duty latch and comparators
  pwm_stage i_pwm_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .tb     (i_tb_if.snk),
    .duty   (i_duty_if.snk),
    .led_r  (led_r),
    .led_g  (led_g),
    .led_b  (led_b)
  );

endmodule

/* logic/pwm_stage.sv */
/*
 * PWM output stage
 * Latches duties once per period and compares them with the PWM count
 * to drive the three LED lines
 */

`timescale 1ns/1ps

module pwm_stage (
  input  logic    clk,
  input  logic    arst_n,
  timebase_if.snk tb,
  duty_if.snk     duty,
  output logic    led_r,
  output logic    led_g,
  output logic    led_b
);

  logic [breath_pkg::pwm_w-1:0]    duty_in [breath_pkg::num_chan];
  logic [breath_pkg::pwm_w-1:0]    active_q [breath_pkg::num_chan];
  logic [breath_pkg::pwm_w-1:0]    cnt_d1_q;  // PWM count, 1 cycle late
  logic [breath_pkg::pwm_w-1:0]    cnt_d2_q;  // Aligned with active duty
  logic [breath_pkg::num_chan-1:0] led_q;

  assign duty_in[breath_pkg::chan_r] = duty.duty_r;
  assign duty_in[breath_pkg::chan_g] = duty.duty_g;
  assign duty_in[breath_pkg::chan_b] = duty.duty_b;

  // Active duties, swapped only on the update strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < breath_pkg::num_chan; i++) begin
        active_q[i] <= '0;  // All lines dark
      end
    end else if (duty.duty_upd) begin
      active_q <= duty_in;
    end
  end

  // Delay PWM count by the envelope and latch latency
  // so step zero meets the new duty
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_d1_q <= '0;
      cnt_d2_q <= '0;
    end else begin
      cnt_d1_q <= tb.pwm_cnt;
      cnt_d2_q <= cnt_d1_q;
    end
  end

  // Comparator per channel, high while count below duty
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led_q <= '0;
    end else begin
      for (int i = 0; i < breath_pkg::num_chan; i++) begin
        led_q[i] <= (cnt_d2_q < active_q[i]);  // Duty 0 never lights
      end
    end
  end

  assign led_r = led_q[breath_pkg::chan_r];
  assign led_g = led_q[breath_pkg::chan_g];
  assign led_b = led_q[breath_pkg::chan_b];

endmodule

/* logic/breath_envelope.sv */
/*
 * Breathing LED envelope
 * Turns each channel's mode and level into a duty value, sampled once
 * per PWM period
 */

`timescale 1ns/1ps

module breath_envelope (
  input  logic                         clk,
  input  logic                         arst_n,
  timebase_if.snk                      tb,
  input  breath_pkg::chan_mode_e       mode_r,
  input  breath_pkg::chan_mode_e       mode_g,
  input  breath_pkg::chan_mode_e       mode_b,
  input  logic [breath_pkg::pwm_w-1:0] level_r,
  input  logic [breath_pkg::pwm_w-1:0] level_g,
  input  logic [breath_pkg::pwm_w-1:0] level_b,
  duty_if.src                          duty
);

  // Duty for one channel
  function automatic logic [breath_pkg::pwm_w-1:0] chan_duty(
    input breath_pkg::chan_mode_e       mode,
    input logic [breath_pkg::pwm_w-1:0] level,
    input logic [breath_pkg::ramp_w-1:0] tri_val,
    input logic                         phase
  );
    logic [breath_pkg::ramp_w+breath_pkg::pwm_w-1:0] prod;
    logic [breath_pkg::pwm_w-1:0]                    res;
    prod = tri_val * level;  // Full 16-bit product
    case (mode)
      breath_pkg::mode_off:     res = '0;
      breath_pkg::mode_steady:  res = level;
      breath_pkg::mode_breathe: res = prod[breath_pkg::ramp_w+breath_pkg::pwm_w-1 -:
                                           breath_pkg::pwm_w];  // Upper byte
      breath_pkg::mode_blink:   res = phase ? '0 : level;  // Lit in first half
      default:                  res = '0;
    endcase
    return res;
  endfunction

  logic [breath_pkg::ramp_w-1:0] tri_val;  // Triangle, shared by all channels
  breath_pkg::chan_mode_e        mode_a [breath_pkg::num_chan];
  logic [breath_pkg::pwm_w-1:0]  level_a [breath_pkg::num_chan];
  logic [breath_pkg::pwm_w-1:0]  duty_nxt [breath_pkg::num_chan];
  logic [breath_pkg::pwm_w-1:0]  duty_q [breath_pkg::num_chan];
  logic                          upd_q;

  // Ramp up in phase 0, mirror in phase 1
  assign tri_val = tb.phase ? (breath_pkg::ramp_w'('1) - tb.ramp) : tb.ramp;

  // Channel inputs into arrays
  assign mode_a[breath_pkg::chan_r]  = mode_r;
  assign mode_a[breath_pkg::chan_g]  = mode_g;
  assign mode_a[breath_pkg::chan_b]  = mode_b;
  assign level_a[breath_pkg::chan_r] = level_r;
  assign level_a[breath_pkg::chan_g] = level_g;
  assign level_a[breath_pkg::chan_b] = level_b;

  always_comb begin
    for (int i = 0; i < breath_pkg::num_chan; i++) begin
      duty_nxt[i] = chan_duty(mode_a[i], level_a[i], tri_val, tb.phase);
    end
  end

  // Duty payload, loaded once per period
  always_ff @(posedge clk) begin
    if (tb.period_start) begin
      duty_q <= duty_nxt;  // Mode and level sampled here only
    end
  end

  // Update strobe one cycle after period_start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      upd_q <= 1'b0;
    end else begin
      upd_q <= tb.period_start;
    end
  end

  assign duty.duty_r   = duty_q[breath_pkg::chan_r];
  assign duty.duty_g   = duty_q[breath_pkg::chan_g];
  assign duty.duty_b   = duty_q[breath_pkg::chan_b];
  assign duty.duty_upd = upd_q;

endmodule

/* logic/breath_timebase.sv */
/*
 * Breathing LED timebase
 * Free-running prescaled counter sliced into PWM count, ramp and phase,
 * with a strobe on the first cycle of each PWM period
 */

`timescale 1ns/1ps

module breath_timebase #(
  parameter int unsigned prescale_w = breath_pkg::prescale_w_default
) (
  input  logic    clk,
  input  logic    arst_n,
  timebase_if.src tb
);

  // Prescaler plus PWM count, ramp and phase
  localparam int unsigned cnt_w = prescale_w + breath_pkg::field_w;
  localparam int unsigned ramp_lsb = prescale_w + breath_pkg::pwm_w;

  logic [cnt_w-1:0]                cnt_q;
  logic [breath_pkg::pwm_w-1:0]    pwm_cnt_q;
  logic [breath_pkg::ramp_w-1:0]   ramp_q;
  logic                            phase_q;
  logic                            start_q;

  // Main counter, wraps freely
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Output fields, one cycle behind the counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pwm_cnt_q <= '0;
      ramp_q    <= '0;
      phase_q   <= 1'b0;
      start_q   <= 1'b0;  // Quiet until counter seen at zero
    end else begin
      pwm_cnt_q <= cnt_q[prescale_w +: breath_pkg::pwm_w];
      ramp_q    <= cnt_q[ramp_lsb +: breath_pkg::ramp_w];
      phase_q   <= cnt_q[cnt_w-1];  // Top bit
      // Prescale and PWM bits all zero, period begins
      start_q   <= (cnt_q[ramp_lsb-1:0] == '0);
    end
  end

  assign tb.pwm_cnt      = pwm_cnt_q;
  assign tb.ramp         = ramp_q;
  assign tb.phase        = phase_q;
  assign tb.period_start = start_q;  // Lines up with pwm_cnt of zero

endmodule

/* logic/duty_if.sv */
/*
 * Per-channel duty values and their update strobe into the PWM stage
 */

`timescale 1ns/1ps

interface duty_if;

  logic [breath_pkg::pwm_w-1:0] duty_r;  // Red duty, high steps per period
  logic [breath_pkg::pwm_w-1:0] duty_g;
  logic [breath_pkg::pwm_w-1:0] duty_b;
  logic                         duty_upd;  // New duties valid this cycle

  // Envelope side
  modport src (
    output duty_r,
    output duty_g,
    output duty_b,
    output duty_upd
  );

  modport snk (
    input duty_r,
    input duty_g,
    input duty_b,
    input duty_upd
  );

endinterface

/* logic/timebase_if.sv */
/*
 * Timebase fields from the counter to the envelope and PWM stages
 */

`timescale 1ns/1ps

interface timebase_if;

  logic [breath_pkg::pwm_w-1:0]  pwm_cnt;       // PWM step within the period
  logic [breath_pkg::ramp_w-1:0] ramp;          // Slow ramp, one step per period
  logic                          phase;         // 0 ramps up, 1 ramps down
  logic                          period_start;  // First cycle of a PWM period

  // Timebase side
  modport src (
    output pwm_cnt,
    output ramp,
    output phase,
    output period_start
  );

  modport snk (
    input pwm_cnt,
    input ramp,
    input phase,
    input period_start
  );

endinterface

/* logic/breath_pkg.sv */
/*
 * RGB breathing LED controller shared definitions
 * Field widths, channel indices, channel modes and default prescale
 */

package breath_pkg;

  // PWM count and duty width
  localparam int unsigned pwm_w = 8;
  localparam int unsigned ramp_w = 8;  // Triangle ramp resolution

  // Timebase bits above the prescaler: PWM count, ramp, phase
  localparam int unsigned field_w = pwm_w + ramp_w + 1;

  localparam int unsigned num_chan = 3;

  // Channel slots in the per-channel arrays
  localparam int unsigned chan_r = 0;
  localparam int unsigned chan_g = 1;
  localparam int unsigned chan_b = 2;

  // 11 prescale bits give the 28-bit board counter
  localparam int unsigned prescale_w_default = 11;

  // Per-channel behaviour
  typedef enum logic [1:0] {
    mode_off     = 2'd0,  // Line held low
    mode_steady  = 2'd1,  // Fixed duty from level
    mode_breathe = 2'd2,  // Triangle scaled by level
    mode_blink   = 2'd3   // Level in phase 0, dark in phase 1
  } chan_mode_e;

endpackage
